// ==== Bender.yml ====
package:
  name: nonogram_frontend

export_include_dirs:
  - include

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/nono_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/clue_parser.sv
      - hdl/line_fifo.sv
      - hdl/line_streamer.sv
      - hdl/nonogram_top.sv
  - target: simulation
    files:
      - tb/tb_nonogram.sv

// ==== files.f ====
+incdir+include
hdl/uart_pkg.sv
hdl/nono_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/clue_parser.sv
hdl/line_fifo.sv
hdl/line_streamer.sv
hdl/nonogram_top.sv
tb/tb_nonogram.sv

// ==== hdl/clue_parser.sv ====
`timescale 1ns/1ps
`include "nono_defs.svh"

module clue_parser (
    input  logic                clk_50mhz,
    input  logic                rst,
    input  logic                byte_valid,
    input  logic [7:0]          byte_data,
    output logic                rec_write,
    output nono_pkg::line_rec_t rec,
    output logic                board_done
);
    import nono_pkg::*;

    typedef enum logic [1:0] {
        p_dim_m,  // row count byte
        p_dim_n,  // column count byte
        p_count,  // clue count of next line
        p_clue    // clue bytes of current line
    } parse_state_t;

    parse_state_t state;
    logic [7:0]   m;          // rows as sent
    logic [7:0]   n;          // cols as sent
    logic         dims_bad;   // m or n outside 1..MAX_DIM
    logic         is_col;
    logic [7:0]   line_cnt;   // index among rows or cols
    logic [7:0]   k_reg;      // clue count of this line
    logic [7:0]   rem;        // clues still to come
    logic [10:0]  sum;        // six clues of 255 still fit
    logic         zero_seen;  // some clue was 0
    logic         last_line;  // record being written ends the board
    logic [7:0]   k_cur;
    logic [10:0]  sum_cur;
    logic         zero_cur;
    logic         line_end;
    logic         board_end;
    logic [7:0]   len;
    int           diff;
    line_rec_t    rec_next;

    // record of the line that the current byte closes
    always_comb begin
        k_cur     = (state == p_count) ? byte_data : k_reg;
        sum_cur   = (state == p_count) ? 11'd0 : sum + 11'(byte_data);
        zero_cur  = (state == p_clue) && (zero_seen || byte_data == 8'd0);
        line_end  = byte_valid && ((state == p_count && byte_data == 8'd0) ||
                                   (state == p_clue && rem == 8'd1));
        board_end = is_col ? (line_cnt + 8'd1 == n)
                           : (line_cnt + 8'd1 == m && n == 8'd0);  // no cols follow
        len       = is_col ? m : n;
        if (k_cur == 8'd0)
            diff = int'(len);  // empty line, all free
        else
            diff = int'(len) - int'(sum_cur) - int'(k_cur) + 1;  // one gap between blocks
        rec_next.is_col     = is_col;
        rec_next.line_index = dim_t'(line_cnt);
        rec_next.clue_count = (k_cur > 8'd7) ? 3'd7 : k_cur[2:0];
        rec_next.bad        = dims_bad || k_cur > 8'd6 || zero_cur || diff < 0;
        rec_next.slack      = rec_next.bad ? 4'd0 : 4'(diff);
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state      <= p_dim_m;
            rec_write  <= 1'b0;
            board_done <= 1'b0;
            last_line  <= 1'b0;
            is_col     <= 1'b0;
            line_cnt   <= '0;
        end else begin
            rec_write  <= line_end;               // one cycle after last byte
            board_done <= rec_write && last_line; // one cycle after final record
            if (line_end) begin
                rec       <= rec_next;
                last_line <= board_end;
            end
            if (byte_valid) begin
                case (state)
                    p_dim_m: begin
                        m     <= byte_data;
                        state <= p_dim_n;
                    end
                    p_dim_n: begin
                        n        <= byte_data;
                        dims_bad <= m == 8'd0 || m > `MAX_DIM ||
                                    byte_data == 8'd0 || byte_data > `MAX_DIM;
                        is_col   <= (m == 8'd0);  // no rows, start on cols
                        line_cnt <= '0;
                        if (m == 8'd0 && byte_data == 8'd0) begin
                            board_done <= 1'b1;  // empty board
                            state      <= p_dim_m;
                        end else begin
                            state <= p_count;
                        end
                    end
                    p_count: begin
                        k_reg     <= byte_data;
                        rem       <= byte_data;
                        sum       <= '0;
                        zero_seen <= 1'b0;
                        if (byte_data != 8'd0) state <= p_clue;
                    end
                    p_clue: begin
                        sum       <= sum_cur;
                        zero_seen <= zero_cur;
                        rem       <= rem - 8'd1;
                    end
                    default: state <= p_dim_m;
                endcase
                if (line_end) begin  // step to next line
                    if (board_end) begin
                        state <= p_dim_m;
                    end else if (!is_col && line_cnt + 8'd1 == m) begin
                        is_col   <= 1'b1;  // rows done
                        line_cnt <= '0;
                        state    <= p_count;
                    end else begin
                        line_cnt <= line_cnt + 8'd1;
                        state    <= p_count;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 32
) (
    input  logic     clk_50mhz,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty,
    output logic     full,
    output logic     overflow
);
    localparam int ptr_w = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;  // occupancy
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == (ptr_w + 1)'(DEPTH));
    assign do_wr = wr_en && !full;   // write on full is lost
    assign do_rd = rd_en && !empty;
    assign dout  = mem[rd_ptr];      // head, valid while !empty

    always_ff @(posedge clk_50mhz) begin
        if (do_wr) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (ptr_w + 1)'(do_wr) - (ptr_w + 1)'(do_rd);
            if (wr_en && full) overflow <= 1'b1;  // sticky until reset
        end
    end

endmodule

// ==== hdl/line_streamer.sv ====
`timescale 1ns/1ps

module line_streamer (
    input  logic                clk_50mhz,
    input  logic                rst,
    input  logic                board_done,
    input  nono_pkg::line_rec_t fifo_data,
    input  logic                fifo_empty,
    input  logic                tx_busy,
    output logic                fifo_pop,
    output logic                tx_start,
    output logic [7:0]          tx_byte,
    output logic                active,
    output logic                streamer_done
);
    import nono_pkg::*;

    typedef enum logic [1:0] {
        s_idle,    // waiting for a complete board
        s_next,    // pop next record or finish
        s_send_a,  // index and clue count byte
        s_send_b   // bad flag and slack byte
    } stream_state_t;

    stream_state_t state;
    line_rec_t     cur;      // record being sent
    logic          tx_free;

    // busy rises a cycle after tx_start, so a pending start also counts
    assign tx_free = !tx_busy && !tx_start;

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state         <= s_idle;
            fifo_pop      <= 1'b0;
            tx_start      <= 1'b0;
            active        <= 1'b0;
            streamer_done <= 1'b0;
        end else begin
            fifo_pop      <= 1'b0;
            tx_start      <= 1'b0;
            streamer_done <= 1'b0;
            case (state)
                s_idle: begin
                    if (board_done) begin
                        active <= 1'b1;
                        state  <= s_next;
                    end
                end
                s_next: begin
                    if (!fifo_empty) begin
                        cur      <= fifo_data;  // head is combinational
                        fifo_pop <= 1'b1;
                        state    <= s_send_a;
                    end else if (tx_free) begin  // last byte left the wire
                        active        <= 1'b0;
                        streamer_done <= 1'b1;
                        state         <= s_idle;
                    end
                end
                s_send_a: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        tx_byte  <= {cur.is_col, cur.line_index, cur.clue_count};
                        state    <= s_send_b;
                    end
                end
                s_send_b: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        tx_byte  <= {3'b000, cur.bad, cur.slack};
                        state    <= s_next;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== hdl/nono_pkg.sv ====
`include "nono_defs.svh"

package nono_pkg;

    localparam int dim_w = $clog2(`MAX_DIM + 1);  // enough for 0..MAX_DIM

    typedef logic [dim_w-1:0] dim_t;  // row/col count or line index

    // one parsed line as handed to the solver stage, 13 bits
    typedef struct packed {
        logic       is_col;      // 0 row, 1 column
        dim_t       line_index;  // position among rows or columns
        logic [2:0] clue_count;  // saturates at 7
        logic       bad;         // clues cannot fit the line
        logic [3:0] slack;       // free cells, 0 when bad
    } line_rec_t;

endpackage

// ==== hdl/nonogram_top.sv ====
`timescale 1ns/1ps
`include "nono_defs.svh"

module nonogram_top (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       rx,
    output logic       tx,
    output logic [7:0] bits,
    output logic [2:0] stat
);
    import uart_pkg::*;
    import nono_pkg::*;

    logic       byte_valid;
    logic [7:0] byte_data;
    rx_state_t  rx_state;
    logic       rec_write;
    line_rec_t  rec;
    logic       board_done;
    line_rec_t  fifo_head;
    logic       fifo_empty;
    logic       overflow;
    logic       fifo_pop;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       active;

    uart_rx rx0 (
        .clk_50mhz  (clk_50mhz),
        .rst        (rst),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .state      (rx_state)
    );

    clue_parser parser0 (
        .clk_50mhz  (clk_50mhz),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .rec_write  (rec_write),
        .rec        (rec),
        .board_done (board_done)
    );

    line_fifo #(
        .payload_t (line_rec_t),
        .DEPTH     (`FIFO_DEPTH)
    ) fifo0 (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .wr_en     (rec_write),
        .din       (rec),
        .rd_en     (fifo_pop),
        .dout      (fifo_head),
        .empty     (fifo_empty),
        .full      (),          // overflow covers the full case
        .overflow  (overflow)
    );

    line_streamer streamer0 (
        .clk_50mhz     (clk_50mhz),
        .rst           (rst),
        .board_done    (board_done),
        .fifo_data     (fifo_head),
        .fifo_empty    (fifo_empty),
        .tx_busy       (tx_busy),
        .fifo_pop      (fifo_pop),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .active        (active),
        .streamer_done ()
    );

    uart_tx tx0 (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx        (tx),
        .busy      (tx_busy)
    );

    always_ff @(posedge clk_50mhz) begin
        if (rst) bits <= '0;
        else if (byte_valid) bits <= byte_data;  // last byte for the leds
    end

    assign stat = {active, overflow, rx_state != rx_st_idle};

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    typedef enum logic [1:0] {
        rx_st_idle,   // line high, waiting for start edge
        rx_st_start,  // checking start bit at its centre
        rx_st_data,   // shifting eight data bits
        rx_st_stop    // stop bit check
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,  // driving the low start bit
        tx_st_data,   // data bits, lsb first
        tx_st_stop
    } tx_state_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`include "nono_defs.svh"

module uart_rx (
    input  logic                clk_50mhz,
    input  logic                rst,
    input  logic                rx,
    output logic                byte_valid,
    output logic [7:0]          byte_data,
    output uart_pkg::rx_state_t state
);
    import uart_pkg::*;

    localparam int cnt_w    = $clog2(`BAUD_DIV);
    localparam int half_bit = `BAUD_DIV / 2;

    logic             rx_meta;  // first sync flop
    logic             rx_sync;  // safe to use
    logic [cnt_w-1:0] cnt;      // cycles into current bit
    logic [2:0]       bit_idx;  // data bit number

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            rx_meta    <= 1'b1;  // idle line is high
            rx_sync    <= 1'b1;
            state      <= rx_st_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_meta    <= rx;
            rx_sync    <= rx_meta;
            byte_valid <= 1'b0;  // one cycle strobe
            case (state)
                rx_st_idle: begin
                    cnt <= '0;
                    if (!rx_sync) state <= rx_st_start;  // falling start edge
                end
                rx_st_start: begin
                    if (cnt == cnt_w'(half_bit - 1)) begin
                        cnt   <= '0;
                        state <= rx_sync ? rx_st_idle : rx_st_data;  // glitch goes back
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    if (cnt == cnt_w'(`BAUD_DIV - 1)) begin  // mid-bit
                        cnt       <= '0;
                        byte_data <= {rx_sync, byte_data[7:1]};  // lsb arrives first
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_st_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_st_stop: begin
                    if (cnt == cnt_w'(`BAUD_DIV - 1)) begin
                        cnt        <= '0;
                        byte_valid <= rx_sync;  // framing error drops the byte
                        state      <= rx_st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`include "nono_defs.svh"

module uart_tx (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       busy
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(`BAUD_DIV);

    tx_state_t        state;
    logic [cnt_w-1:0] cnt;      // cycles into current bit
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;    // remaining data bits
    logic             bit_end;

    assign bit_end = (cnt == cnt_w'(`BAUD_DIV - 1));

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state   <= tx_st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;  // line idles high
            busy    <= 1'b0;
        end else begin
            cnt <= (state == tx_st_idle || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                tx_st_idle: begin
                    if (tx_start) begin
                        shreg <= tx_byte;  // latched for the whole frame
                        tx    <= 1'b0;     // start bit
                        busy  <= 1'b1;
                        state <= tx_st_start;
                    end
                end
                tx_st_start: begin
                    if (bit_end) begin
                        tx      <= shreg[0];
                        shreg   <= shreg >> 1;
                        bit_idx <= '0;
                        state   <= tx_st_data;
                    end
                end
                tx_st_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;  // stop bit
                            state <= tx_st_stop;
                        end else begin
                            tx      <= shreg[0];
                            shreg   <= shreg >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                tx_st_stop: begin
                    if (bit_end) begin
                        busy  <= 1'b0;  // frame done, 10 bits
                        state <= tx_st_idle;
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

endmodule

// ==== include/nono_defs.svh ====
`ifndef NONO_DEFS_SVH
`define NONO_DEFS_SVH

`define MAX_DIM    11   // largest row or column count
`define BAUD_DIV   434  // 50 MHz / 115200 baud
`define FIFO_DEPTH 32   // 22 lines of an 11x11 board plus headroom

`endif

// ==== tb/nonogram_stim.txt ====
# test name, then input byte count and bytes, then echo byte count and bytes
# all numbers hex; each record echoes as {is_col,index,clues} then {000,bad,slack}
simple_3x3
0F 03 03 01 01 02 01 01 01 02 01 03 01 01 01 01
0C 01 02 0A 00 11 01 81 00 89 02 91 02
empty_and_full_lines
0C 02 04 00 02 01 02 00 01 02 01 01 00
0C 00 04 0A 00 80 02 89 00 91 01 98 02
bad_lines
18 03 04 02 03 02 02 01 00 07 01 01 01 01 01 01 01 01 01 02 01 01 00 01 03
0E 02 10 0A 10 17 10 81 02 8A 00 90 03 99 00
board_11x11
25 0B 0B 01 01 01 02 01 03 01 04 01 05 01 06 01 07 01 08 01 09 01 0A 01 0B
00 00 00 00 00 00 00 00 00 00 02 05 05
2C 01 0A 09 09 11 08 19 07 21 06 29 05 31 04 39 03 41 02 49 01 51 00
80 0B 88 0B 90 0B 98 0B A0 0B A8 0B B0 0B B8 0B C0 0B C8 0B D2 00
back_to_back
13 02 02 01 01 01 02 00 01 01 01 03 02 01 01 01 01 00 01 01
10 01 01 09 00 80 02 89 01 02 00 81 00 88 01 91 00
dim_zero
05 00 02 01 01 00
04 81 10 88 10
dim_twelve
0F 01 0C 00 00 00 00 00 00 00 00 00 00 00 00 00
1A 00 10 80 10 88 10 90 10 98 10 A0 10 A8 10 B0 10 B8 10 C0 10 C8 10 D0 10 D8 10

// ==== tb/tb_nonogram.sv ====
`timescale 1ns/1ps
`include "nono_defs.svh"

module tb_nonogram;

    localparam int max_gap = 64;  // idle cycles between host bytes, well under a bit

    logic        clk_50mhz;
    logic        rst;
    logic        rx;
    logic        tx;
    logic [7:0]  bits;
    logic [2:0]  stat;

    logic [31:0] rng_state;
    int          fd;
    int          tests_run;
    string       test_name;
    logic [7:0]  in_q[$];   // host bytes of current test
    logic [7:0]  exp_q[$];  // expected echo
    logic [7:0]  got_q[$];  // echo seen on tx

    nonogram_top dut0 (
        .clk_50mhz (clk_50mhz),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .bits      (bits),
        .stat      (stat)
    );

    initial begin
        clk_50mhz = 1'b0;
        forever #10 clk_50mhz = ~clk_50mhz;  // 20 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // host side frame, caller sits on a rising edge
    task automatic drive_frame(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        int         gap;
        frame = {1'b1, b, 1'b0};  // stop, data, start
        for (i = 0; i < 10; i++) begin
            rx <= frame[i];  // lsb first after start
            repeat (`BAUD_DIV) @(posedge clk_50mhz);
            if (i == 4) begin  // middle of the data bits, receiver is busy
                assert (stat[0] === 1'b1) else
                    abort_run($sformatf("FAILED %s rx busy: expected 1, actual %b",
                                        test_name, stat[0]));
            end
        end
        rng_state = xorshift(rng_state);
        gap       = int'(rng_state % max_gap);
        repeat (gap) @(posedge clk_50mhz);
    endtask

    // one echo byte, sampled on falling edges where tx is settled
    task automatic receive_frame(input int limit);
        logic [7:0] b;
        int         cnt;
        int         i;
        cnt = 0;
        @(negedge clk_50mhz);
        while (tx !== 1'b0) begin  // start bit
            cnt++;
            if (cnt > limit)
                abort_run($sformatf("timeout waiting for start bit of echo byte %0d in %s",
                                    got_q.size(), test_name));
            @(negedge clk_50mhz);
        end
        repeat (`BAUD_DIV / 2) @(negedge clk_50mhz);  // centre of start bit
        assert (tx === 1'b0) else abort_run("start bit on tx shorter than half a bit");
        assert (stat[2] === 1'b1) else  // streamer owns the line during a frame
            abort_run($sformatf("FAILED %s active: expected 1, actual %b",
                                test_name, stat[2]));
        for (i = 0; i < 8; i++) begin
            repeat (`BAUD_DIV) @(negedge clk_50mhz);
            b[i] = tx;
        end
        repeat (`BAUD_DIV) @(negedge clk_50mhz);
        assert (tx === 1'b1) else abort_run("stop bit on tx sampled low");
        got_q.push_back(b);
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (stat[2] !== 1'b0) begin  // streamer active
            cnt++;
            if (cnt > 2 * `BAUD_DIV)
                abort_run($sformatf("timeout waiting for streamer to go idle in %s", test_name));
            @(negedge clk_50mhz);
        end
        repeat (2 * `BAUD_DIV) begin  // no stray echo after the last record
            @(negedge clk_50mhz);
            assert (tx === 1'b1) else abort_run("tx left idle after the expected echo");
        end
    endtask

    task automatic read_hex(output int v);
        int code;
        code = $fscanf(fd, "%h", v);
        if (code != 1) abort_run("stimulus file ends inside a test or holds a bad number");
    endtask

    task automatic run_test();
        int ia;
        int ib;
        int i;
        int limit;
        limit = (in_q.size() + 8) * 16 * `BAUD_DIV;  // whole input may precede the echo
        fork
            begin
                @(posedge clk_50mhz);
                for (ia = 0; ia < in_q.size(); ia++) drive_frame(in_q[ia]);
            end
            begin
                for (ib = 0; ib < exp_q.size(); ib++) receive_frame(limit);
            end
        join
        wait_idle();
        for (i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i] === exp_q[i]) else
                abort_run($sformatf("FAILED %s echo byte %0d: expected %02h, actual %02h",
                                    test_name, i, exp_q[i], got_q[i]));
        end
        assert (bits === in_q[in_q.size() - 1]) else  // last received byte
            abort_run($sformatf("FAILED %s bits: expected %02h, actual %02h",
                                test_name, in_q[in_q.size() - 1], bits));
        assert (stat[1] === 1'b0) else
            abort_run($sformatf("FAILED %s overflow: expected 0, actual %b",
                                test_name, stat[1]));
        assert (stat[0] === 1'b0) else  // receiver back in idle
            abort_run($sformatf("FAILED %s rx busy: expected 0, actual %b",
                                test_name, stat[0]));
    endtask

    initial begin
        string tok;
        string rest;
        int    code;
        int    n;
        int    v;
        int    i;
        rst       = 1'b1;
        rx        = 1'b1;  // line idle
        rng_state = 32'h1da4270a;
        tests_run = 0;
        fd = $fopen("tb/nonogram_stim.txt", "r");
        if (fd == 0) abort_run("cannot open tb/nonogram_stim.txt");
        repeat (4) @(posedge clk_50mhz);
        rst <= 1'b0;
        repeat (4) @(posedge clk_50mhz);
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);  // rest of comment line
            end else begin
                test_name = tok;
                in_q.delete();
                exp_q.delete();
                got_q.delete();
                read_hex(n);
                for (i = 0; i < n; i++) begin
                    read_hex(v);
                    in_q.push_back(8'(v));
                end
                read_hex(n);
                for (i = 0; i < n; i++) begin
                    read_hex(v);
                    exp_q.push_back(8'(v));
                end
                run_test();
                tests_run++;
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        assert (tests_run > 0) else abort_run("no test found in the stimulus file");
        $display("*** PASSED ***");
        $finish;
    end

endmodule
